/* include/issue_macros.svh */
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// register file addressing
`define REG_ADDR_WIDTH 5

// in-flight table, one commit id per entry
`define COMMIT_ID_WIDTH 3
`define SB_DEPTH 8

// datapath width
`define XLEN 32

// fixed unit latencies, accept edge to commit edge
`define MUL_LATENCY 3
`define DIV_CYCLES 32   // one quotient bit per cycle

`endif

/* hdl/issue_pkg.sv */
`default_nettype none

// shared types of the long-instruction issue stage
package issue_pkg;

    // unit that executes an instruction
    // also tags the table entry it owns
    typedef enum logic {
        EXU_MUL = 1'b0, // pipelined multiplier, completion port 0
        EXU_DIV = 1'b1  // iterative divider, completion port 1
    } exu_t;

endpackage

`default_nettype wire

/* hdl/issue_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

// scoreboard to unit, one item per accepted instruction
interface dispatch_if #(
    parameter issue_pkg::exu_t UNIT = issue_pkg::EXU_MUL // unit behind this port
);
    logic                        valid;  // single-cycle, no back-pressure
    logic [`COMMIT_ID_WIDTH-1:0] id;     // table entry owned by the op
    logic [`REG_ADDR_WIDTH-1:0]  rd;
    logic [`XLEN-1:0]            op_a;
    logic [`XLEN-1:0]            op_b;

    modport src (output valid, output id, output rd, output op_a, output op_b);
    modport dst (input valid, input id, input rd, input op_a, input op_b);
endinterface

// unit completion, also the writeback
interface commit_if;
    logic                        valid;  // one-cycle pulse
    logic [`COMMIT_ID_WIDTH-1:0] id;     // frees this entry
    logic [`REG_ADDR_WIDTH-1:0]  rd;
    logic [`XLEN-1:0]            data;

    modport src (output valid, output id, output rd, output data);
    modport mon (input valid, input id, input rd, input data);
endinterface

`default_nettype wire

/* hdl/hazard_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module hazard_scoreboard (
    input  logic                       clk,
    input  logic                       rst_n,

    // decoded long instruction
    input  logic                       issue_valid_i,
    input  logic                       rd_we_i,
    input  logic                       rs1_re_i,
    input  logic                       rs2_re_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rd_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2_i,
    input  issue_pkg::exu_t            exu_i,
    input  logic [`XLEN-1:0]           op_a_i,
    input  logic [`XLEN-1:0]           op_b_i,

    input  logic                       div_ready_i, // divider idle

    dispatch_if.src                    mul_disp,
    dispatch_if.src                    div_disp,
    commit_if.mon                      mul_cmt,
    commit_if.mon                      div_cmt,

    output logic                       stall_o,
    output logic                       busy_o
);
    import issue_pkg::*;

    // in-flight table
    logic [`SB_DEPTH-1:0]        ent_vld_q;
    logic [`REG_ADDR_WIDTH-1:0]  ent_rd_q [`SB_DEPTH];
    exu_t                        ent_exu_q [`SB_DEPTH];

    logic [`SB_DEPTH-1:0]        cmt_hit;   // entry completing this cycle
    logic [`SB_DEPTH-1:0]        live;      // valid and not completing
    logic [`SB_DEPTH-1:0]        raw_vec;
    logic [`SB_DEPTH-1:0]        waw_vec;
    logic [`SB_DEPTH-1:0]        set_vec;

    logic                        tbl_full;
    logic                        div_block;
    logic                        accept;
    logic                        alloc;     // accepted and writes rd
    logic [`COMMIT_ID_WIDTH-1:0] free_id;

    // per-entry hazard vectors
    for (genvar i = 0; i < `SB_DEPTH; i++) begin : g_ent
        assign cmt_hit[i] = (mul_cmt.valid && mul_cmt.id == `COMMIT_ID_WIDTH'(i))
                         || (div_cmt.valid && div_cmt.id == `COMMIT_ID_WIDTH'(i));
        assign live[i]    = ent_vld_q[i] && !cmt_hit[i]; // commit frees it for checks

        assign raw_vec[i] = live[i]
                         && ((rs1_re_i && rs1_i == ent_rd_q[i])
                          || (rs2_re_i && rs2_i == ent_rd_q[i]));

        // same unit retires in order, so only a cross-unit WAW matters
        assign waw_vec[i] = live[i] && rd_we_i
                         && rd_i == ent_rd_q[i]
                         && exu_i != ent_exu_q[i];
    end

    // a committing entry is still occupied for allocation
    assign tbl_full  = &ent_vld_q;
    assign div_block = rd_we_i && exu_i == EXU_DIV && !div_ready_i;

    assign stall_o = (|raw_vec) || (|waw_vec) || tbl_full || div_block;
    assign accept  = issue_valid_i && !stall_o;
    assign alloc   = accept && rd_we_i; // no rd write, hazard check only

    // lowest free entry, last hit of a descending scan wins
    always_comb begin
        free_id = '0;
        for (int i = `SB_DEPTH - 1; i >= 0; i--) begin
            if (!ent_vld_q[i]) begin
                free_id = `COMMIT_ID_WIDTH'(i);
            end
        end
    end

    assign set_vec = alloc ? (`SB_DEPTH'(1) << free_id) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_vld_q <= '0;
        end else begin
            ent_vld_q <= (ent_vld_q & ~cmt_hit) | set_vec; // free never collides with set
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_rd_q[free_id]  <= rd_i;
            ent_exu_q[free_id] <= exu_i;
        end
    end

    // dispatch, valid only toward the selected unit
    assign mul_disp.valid = alloc && exu_i == mul_disp.UNIT;
    assign mul_disp.id    = free_id;
    assign mul_disp.rd    = rd_i;
    assign mul_disp.op_a  = op_a_i;
    assign mul_disp.op_b  = op_b_i;

    assign div_disp.valid = alloc && exu_i == div_disp.UNIT;
    assign div_disp.id    = free_id;
    assign div_disp.rd    = rd_i;
    assign div_disp.op_a  = op_a_i;
    assign div_disp.op_b  = op_b_i;

    assign busy_o = |ent_vld_q; // anything in flight

endmodule

`default_nettype wire

/* hdl/mul_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module mul_pipe (
    input  logic    clk,
    input  logic    rst_n,
    dispatch_if.dst disp,
    commit_if.src   cmt
);
    localparam int L = `MUL_LATENCY;

    // tag pipeline, index L-1 is the completing stage
    logic [L-1:0]                vld_q;
    logic [`COMMIT_ID_WIDTH-1:0] id_q [L];
    logic [`REG_ADDR_WIDTH-1:0]  rd_q [L];

    logic [`XLEN-1:0]            a_q;     // stage one operands
    logic [`XLEN-1:0]            b_q;
    logic [2*`XLEN-1:0]          prod_q;  // stage two full product
    logic [`XLEN-1:0]            lo_q;    // stage three low word

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[L-2:0], disp.valid};
        end
    end

    always_ff @(posedge clk) begin
        id_q[0] <= disp.id;
        rd_q[0] <= disp.rd;
        for (int i = 1; i < L; i++) begin
            id_q[i] <= id_q[i-1];
            rd_q[i] <= rd_q[i-1];
        end

        a_q    <= disp.op_a;
        b_q    <= disp.op_b;
        prod_q <= a_q * b_q;          // unsigned, upper half dropped next
        lo_q   <= prod_q[`XLEN-1:0];
    end

    assign cmt.valid = vld_q[L-1];
    assign cmt.id    = id_q[L-1];
    assign cmt.rd    = rd_q[L-1];
    assign cmt.data  = lo_q;

endmodule

`default_nettype wire

/* hdl/div_iter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module div_iter (
    input  logic    clk,
    input  logic    rst_n,
    dispatch_if.dst disp,
    commit_if.src   cmt,
    output logic    ready_o
);
    localparam int CNT_W = $clog2(`DIV_CYCLES + 1); // 0..32 needs 6 bits

    logic                        busy_q;
    logic [CNT_W-1:0]            cnt_q;     // iterations done
    logic [`XLEN-1:0]            quo_q;     // dividend shifts out, quotient in
    logic [`XLEN-1:0]            rem_q;
    logic [`XLEN-1:0]            dvs_q;     // divisor
    logic [`COMMIT_ID_WIDTH-1:0] id_q;
    logic [`REG_ADDR_WIDTH-1:0]  rd_q;

    logic                        start;
    logic                        done;      // commit cycle
    logic [`XLEN:0]              rem_sh;    // remainder with next dividend bit
    logic [`XLEN:0]              trial;
    logic                        fits;

    assign start = disp.valid && !busy_q;
    assign done  = busy_q && cnt_q == CNT_W'(`DIV_CYCLES);

    // restoring step
    assign rem_sh = {rem_q, quo_q[`XLEN-1]};
    assign trial  = rem_sh - {1'b0, dvs_q};
    assign fits   = !trial[`XLEN];   // no borrow, divisor zero always fits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (done) begin
            busy_q <= 1'b0;          // ready again after the commit cycle
        end else if (busy_q) begin
            cnt_q  <= cnt_q + 1'b1;
        end
    end

    // datapath and tag, no reset
    always_ff @(posedge clk) begin
        if (start) begin
            quo_q <= disp.op_a;
            dvs_q <= disp.op_b;
            rem_q <= '0;
            id_q  <= disp.id;
            rd_q  <= disp.rd;
        end else if (busy_q && !done) begin
            if (fits) begin
                rem_q <= trial[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_sh[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b0};
            end
        end
    end

    assign ready_o   = !busy_q;

    assign cmt.valid = done;
    assign cmt.id    = id_q;
    assign cmt.rd    = rd_q;
    assign cmt.data  = quo_q;   // all ones on divide by zero

endmodule

`default_nettype wire

/* hdl/issue_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module issue_top (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       issue_valid_i,
    input  logic                       rd_we_i,
    input  logic                       rs1_re_i,
    input  logic                       rs2_re_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rd_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2_i,
    input  issue_pkg::exu_t            exu_i,
    input  logic [`XLEN-1:0]           op_a_i,
    input  logic [`XLEN-1:0]           op_b_i,

    output logic                       stall_o,
    output logic                       busy_o,

    // writeback, port 0
    output logic                       mul_wb_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0] mul_wb_rd_o,
    output logic [`XLEN-1:0]           mul_wb_data_o,

    // writeback, port 1
    output logic                       div_wb_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0] div_wb_rd_o,
    output logic [`XLEN-1:0]           div_wb_data_o
);
    import issue_pkg::*;

    logic div_ready;

    dispatch_if #(.UNIT(EXU_MUL)) mul_disp_if ();
    dispatch_if #(.UNIT(EXU_DIV)) div_disp_if ();
    commit_if                     mul_cmt_if ();
    commit_if                     div_cmt_if ();

    hazard_scoreboard u_sb (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid_i (issue_valid_i),
        .rd_we_i       (rd_we_i),
        .rs1_re_i      (rs1_re_i),
        .rs2_re_i      (rs2_re_i),
        .rd_i          (rd_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .exu_i         (exu_i),
        .op_a_i        (op_a_i),
        .op_b_i        (op_b_i),
        .div_ready_i   (div_ready),
        .mul_disp      (mul_disp_if.src),
        .div_disp      (div_disp_if.src),
        .mul_cmt       (mul_cmt_if.mon),
        .div_cmt       (div_cmt_if.mon),
        .stall_o       (stall_o),
        .busy_o        (busy_o)
    );

    mul_pipe u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .disp  (mul_disp_if.dst),
        .cmt   (mul_cmt_if.src)
    );

    div_iter u_div (
        .clk     (clk),
        .rst_n   (rst_n),
        .disp    (div_disp_if.dst),
        .cmt     (div_cmt_if.src),
        .ready_o (div_ready)
    );

    // completions leave as writebacks, id stays inside
    assign mul_wb_valid_o = mul_cmt_if.valid;
    assign mul_wb_rd_o    = mul_cmt_if.rd;
    assign mul_wb_data_o  = mul_cmt_if.data;

    assign div_wb_valid_o = div_cmt_if.valid;
    assign div_wb_rd_o    = div_cmt_if.rd;
    assign div_wb_data_o  = div_cmt_if.data;

endmodule

`default_nettype wire

/* dv/issue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module issue_tb;
    import issue_pkg::*;

    // instructions per test
    localparam int N_MUL = 120;
    localparam int N_DIV = 16;
    localparam int N_RAW = 150;
    localparam int N_WAW = 150;
    localparam int N_OCC = 100;
    localparam int WATCHDOG_CYCLES = (N_MUL + N_DIV + N_RAW + N_WAW + N_OCC) * 40 + 500;

    // one expected writeback, cyc is the commit cycle
    typedef struct packed {
        int                         cyc;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`XLEN-1:0]           data;
    } wb_exp_t;

    logic clk, rst_n;
    logic issue_valid, rd_we, rs1_re, rs2_re;
    logic [`REG_ADDR_WIDTH-1:0] rd, rs1, rs2;
    exu_t exu;
    logic [`XLEN-1:0] op_a, op_b;
    logic stall, busy;
    logic mul_wb_valid, div_wb_valid;
    logic [`REG_ADDR_WIDTH-1:0] mul_wb_rd, div_wb_rd;
    logic [`XLEN-1:0] mul_wb_data, div_wb_data;

    issue_top dut0 (
        .clk (clk), .rst_n (rst_n),
        .issue_valid_i (issue_valid), .rd_we_i (rd_we),
        .rs1_re_i (rs1_re), .rs2_re_i (rs2_re),
        .rd_i (rd), .rs1_i (rs1), .rs2_i (rs2), .exu_i (exu),
        .op_a_i (op_a), .op_b_i (op_b),
        .stall_o (stall), .busy_o (busy),
        .mul_wb_valid_o (mul_wb_valid), .mul_wb_rd_o (mul_wb_rd), .mul_wb_data_o (mul_wb_data),
        .div_wb_valid_o (div_wb_valid), .div_wb_rd_o (div_wb_rd), .div_wb_data_o (div_wb_data)
    );

    // reference table
    logic [`SB_DEPTH-1:0]       ent_vld;
    logic [`REG_ADDR_WIDTH-1:0] ent_rd [`SB_DEPTH];
    exu_t                       ent_exu [`SB_DEPTH];
    int                         ent_cyc [`SB_DEPTH];  // cycle of its commit
    int                         div_free_cyc;         // divider idle from here on
    int                         cyc;                  // model cycle count
    wb_exp_t                    mul_q [$];
    wb_exp_t                    div_q [$];

    logic [31:0] lcg_state = 32'd50;
    int err_cnt = 0;
    int test_cnt = 0;
    int stall_cnt = 0;
    int peak_occ = 0;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // 0..n-1, upper bits only since low LCG bits cycle fast
    function automatic int pick_below(input int n);
        logic [31:0] r;
        r = next_random();
        return int'(r[31:16]) % n;
    endfunction

    function automatic logic [`XLEN-1:0] random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi[31:16], lo[31:16]};
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error: %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic check_wb(input string port, input logic vld, input logic due,
                            input logic [`REG_ADDR_WIDTH-1:0] got_rd,
                            input logic [`XLEN-1:0] got_data, input wb_exp_t exp);
        if (due && vld !== 1'b1) begin
            err_cnt++;
            $display("%s writeback to rd %0d did not arrive in cycle %0d", port, exp.rd, cyc);
        end else if (!due && vld !== 1'b0) begin
            err_cnt++;
            $display("%s writeback to rd %0d came with nothing pending in cycle %0d",
                     port, got_rd, cyc);
        end else if (due) begin
            if (got_rd !== exp.rd) begin
                err_cnt++;
                $display("error: %s_wb_rd_o got 0x%0h expected 0x%0h at cycle %0d",
                         port, got_rd, exp.rd, cyc);
            end
            if (got_data !== exp.data) begin
                err_cnt++;
                $display("error: %s_wb_data_o got 0x%0h expected 0x%0h at cycle %0d",
                         port, got_data, exp.data, cyc);
            end
        end
    endtask

    // checks one cycle against the model, then steps the model over the edge
    task automatic eval_cycle(output logic accepted);
        logic                 mul_due, div_due, raw, waw, exp_stall;
        logic [`SB_DEPTH-1:0] live;
        logic [2*`XLEN-1:0]   prod;
        wb_exp_t              item;
        int                   free_id;
        mul_due = mul_q.size() > 0 && mul_q[0].cyc == cyc;
        div_due = div_q.size() > 0 && div_q[0].cyc == cyc;
        check_wb("mul", mul_wb_valid, mul_due, mul_wb_rd, mul_wb_data, mul_due ? mul_q[0] : '0);
        check_wb("div", div_wb_valid, div_due, div_wb_rd, div_wb_data, div_due ? div_q[0] : '0);
        if (mul_due) void'(mul_q.pop_front());
        if (div_due) void'(div_q.pop_front());
        raw = 1'b0;
        waw = 1'b0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            live[i] = ent_vld[i] && ent_cyc[i] != cyc;  // committing counts as free
            if (live[i] && ((rs1_re && rs1 == ent_rd[i]) || (rs2_re && rs2 == ent_rd[i])))
                raw = 1'b1;
            if (live[i] && rd_we && rd == ent_rd[i] && exu != ent_exu[i])
                waw = 1'b1;  // cross-unit only
        end
        exp_stall = raw || waw || (&ent_vld) || (rd_we && exu == EXU_DIV && cyc < div_free_cyc);
        check_flag("stall_o", stall, exp_stall);
        check_flag("busy_o", busy, |ent_vld);
        accepted = issue_valid && !exp_stall;
        if (issue_valid && exp_stall) stall_cnt++;
        if ($countones(ent_vld) > peak_occ) peak_occ = $countones(ent_vld);
        free_id = -1;
        for (int i = `SB_DEPTH - 1; i >= 0; i--) begin
            if (!ent_vld[i]) free_id = i;  // lowest wins
        end
        @(posedge clk);
        for (int i = 0; i < `SB_DEPTH; i++) begin
            if (ent_vld[i] && ent_cyc[i] == cyc) ent_vld[i] = 1'b0;
        end
        if (accepted && rd_we && free_id >= 0) begin
            ent_vld[free_id] = 1'b1;
            ent_rd[free_id]  = rd;
            ent_exu[free_id] = exu;
            item.rd = rd;
            if (exu == EXU_MUL) begin
                prod      = {{`XLEN{1'b0}}, op_a} * {{`XLEN{1'b0}}, op_b};
                item.data = prod[`XLEN-1:0];     // low word only
                item.cyc  = cyc + `MUL_LATENCY;
                mul_q.push_back(item);
            end else begin
                item.data    = (op_b == '0) ? '1 : op_a / op_b;
                item.cyc     = cyc + `DIV_CYCLES + 1;
                div_free_cyc = cyc + `DIV_CYCLES + 2; // ready again after commit
                div_q.push_back(item);
            end
            ent_cyc[free_id] = item.cyc;
        end
        cyc++;
    endtask

    task automatic gen_instr(input int mode);
        issue_valid = 1'b1;
        op_a = random_word();
        op_b = random_word();
        rd_we = 1'b1;
        rs1_re = 1'b0;
        rs2_re = 1'b0;
        rd  = `REG_ADDR_WIDTH'(pick_below(32));
        rs1 = `REG_ADDR_WIDTH'(pick_below(32));
        rs2 = `REG_ADDR_WIDTH'(pick_below(32));
        case (mode)
            0: exu = EXU_MUL;  // independent, no reads
            1: begin
                exu = EXU_DIV;
                if (pick_below(4) == 0) op_b = '0;
                else op_b = op_b >> pick_below(32);  // mix of divisor sizes
            end
            2: begin  // reads on a tiny register range
                exu = (pick_below(8) == 0) ? EXU_DIV : EXU_MUL;
                rd_we  = pick_below(8) != 0;
                rs1_re = pick_below(2) == 1;
                rs2_re = pick_below(2) == 1;
                rd  = `REG_ADDR_WIDTH'(pick_below(4));
                rs1 = `REG_ADDR_WIDTH'(pick_below(4));
                rs2 = `REG_ADDR_WIDTH'(pick_below(4));
            end
            3: begin  // writes to two registers
                exu = (pick_below(3) == 0) ? EXU_DIV : EXU_MUL;
                rd  = `REG_ADDR_WIDTH'(pick_below(2));
            end
            default: begin
                exu = (pick_below(4) == 0) ? EXU_DIV : EXU_MUL;
                rs1_re = pick_below(4) == 0;
                rs2_re = pick_below(4) == 0;
            end
        endcase
    endtask

    task automatic run_test(input string name, input int mode, input int n_instr,
                            input int idle_pct);
        int   issued;
        int   errs_before;
        logic pending;
        logic acc;
        issued = 0;
        errs_before = err_cnt;
        stall_cnt = 0;
        peak_occ = 0;
        pending = 1'b0;
        while (issued < n_instr) begin
            @(negedge clk);
            if (!pending) begin
                if (pick_below(100) < idle_pct) begin
                    issue_valid = 1'b0;
                end else begin
                    gen_instr(mode);
                    pending = 1'b1;  // held until accepted
                end
            end
            #1;
            eval_cycle(acc);
            if (acc) begin
                issued++;
                pending = 1'b0;
            end
        end
        test_cnt++;
        $display("test %s: %0d issued, %0d stalled cycles, peak occupancy %0d, %0d errors",
                 name, issued, stall_cnt, peak_occ, err_cnt - errs_before);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic acc;
        rst_n = 1'b0;
        issue_valid = 1'b0;
        rd_we = 1'b0;
        rs1_re = 1'b0;
        rs2_re = 1'b0;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        exu = EXU_MUL;
        op_a = '0;
        op_b = '0;
        ent_vld = '0;
        cyc = 0;
        div_free_cyc = 0;
        for (int i = 0; i < `SB_DEPTH; i++) ent_cyc[i] = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_flag("stall_o", stall, 1'b0);
        check_flag("busy_o", busy, 1'b0);
        check_flag("mul_wb_valid_o", mul_wb_valid, 1'b0);
        check_flag("div_wb_valid_o", div_wb_valid, 1'b0);

        run_test("mul", 0, N_MUL, 10);
        run_test("div", 1, N_DIV, 20);
        run_test("raw", 2, N_RAW, 15);
        run_test("waw", 3, N_WAW, 15);
        run_test("occupancy", 4, N_OCC, 0);

        // drain, then a few idle cycles to catch stray writebacks
        while (ent_vld != '0 || mul_q.size() > 0 || div_q.size() > 0) begin
            @(negedge clk);
            issue_valid = 1'b0;
            #1;
            eval_cycle(acc);
        end
        repeat (8) begin
            @(negedge clk);
            #1;
            eval_cycle(acc);
        end

        $display("tests %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
hdl/issue_pkg.sv
hdl/issue_ifs.sv
hdl/hazard_scoreboard.sv
hdl/mul_pipe.sv
hdl/div_iter.sv
hdl/issue_top.sv
dv/issue_tb.sv

/* Makefile */
SIM  := obj_dir/Vissue_tb
SRCS := $(wildcard hdl/*.sv dv/*.sv include/*.svh)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Finished with no errors" sim.log

$(SIM): $(SRCS) project.f
	verilator --binary -Wno-fatal --top-module issue_tb -f project.f -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log
